//--- rtl/sample_link_pkg.sv
// Shared widths, settings-bus addresses and framer constants
// for the receive sample to serdes link

package sample_link_pkg;

   ////////////////////////////////////////
   // Bus and data widths
   typedef logic [7:0]  set_addr_t;     // Settings address
   typedef logic [31:0] set_data_t;     // Settings data
   typedef logic [31:0] sample_t;       // One receive sample, I in high half
   typedef logic [15:0] ser_word_t;     // One transceiver word
   typedef logic [7:0]  led_t;
   typedef logic [3:0]  ser_ctrl_t;     // enable, prbsen, loopen, rx_en
   typedef logic [31:0] timer_cnt_t;

   ////////////////////////////////////////
   // Settings register map
   localparam set_addr_t SR_SERDES   = 8'd1;
   localparam set_addr_t SR_LED_SW   = 8'd3;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   localparam set_addr_t SR_SIMTIMER = 8'd198;  // One-shot, periodic at +1

   // 1 selects hardware source for that LED
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

   ////////////////////////////////////////
   // Sample FIFO and framer
   localparam int FIFO_AW = 4;          // 16 words, 8 samples

   // K28.5 in the low byte, sent with tklsb set
   localparam ser_word_t IDLE_WORD = 16'h50BC;

   localparam int SYNC_LEN = 8;         // Idle words after enable

   typedef enum logic [1:0] {
      FR_OFF,
      FR_SYNC,
      FR_RUN
   } framer_state_t;

endpackage

//--- rtl/setting_regs.sv
// Control registers on the settings bus: serdes control,
// software LED value, LED source mask and the LED mix

`timescale 1ns/10ps

module setting_regs (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  logic                        set_stb_i,
   input  sample_link_pkg::set_addr_t  set_addr_i,
   input  sample_link_pkg::set_data_t  set_data_i,
   input  logic                        run_tx_i,
   input  logic                        link_up_i,
   output sample_link_pkg::ser_ctrl_t  ser_ctrl_o,
   output sample_link_pkg::led_t       leds_o
);

   sample_link_pkg::led_t led_sw;
   sample_link_pkg::led_t led_src;
   sample_link_pkg::led_t led_hw;

   logic wr_serdes;
   logic wr_led_sw;
   logic wr_led_src;

   ////////////////////////////////////////
   // Address decode
   assign wr_serdes  = set_stb_i && (set_addr_i == sample_link_pkg::SR_SERDES);
   assign wr_led_sw  = set_stb_i && (set_addr_i == sample_link_pkg::SR_LED_SW);
   assign wr_led_src = set_stb_i && (set_addr_i == sample_link_pkg::SR_LED_SRC);

   ////////////////////////////////////////
   // Registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ser_ctrl_o <= '0;                          // Serdes held off
         led_sw     <= '0;
         led_src    <= sample_link_pkg::LED_SRC_RESET;
      end else begin
         if (wr_serdes) begin
            ser_ctrl_o <= set_data_i[3:0];
         end
         if (wr_led_sw) begin
            led_sw <= set_data_i[7:0];
         end
         if (wr_led_src) begin
            led_src <= set_data_i[7:0];
         end
      end
   end

   ////////////////////////////////////////
   // LED mix
   // Bit 4 tx running, bit 3 rx running, bit 2 clock status (unused here),
   // bit 1 serdes link up
   assign led_hw = {3'b000,
                    run_tx_i,
                    ~run_tx_i,        // Receive path runs whenever tx is idle
                    1'b0,
                    link_up_i,
                    1'b0};

   // Mask bit high takes the hardware source
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- rtl/event_timer.sv
// One-shot and periodic interrupt timers loaded from the settings bus

`timescale 1ns/10ps

module event_timer (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  logic                        set_stb_i,
   input  sample_link_pkg::set_addr_t  set_addr_i,
   input  sample_link_pkg::set_data_t  set_data_i,
   output logic                        onetime_int_o,
   output logic                        periodic_int_o
);

   sample_link_pkg::timer_cnt_t onetime_cnt;
   sample_link_pkg::timer_cnt_t period;
   sample_link_pkg::timer_cnt_t period_cnt;

   logic wr_onetime;
   logic wr_periodic;

   assign wr_onetime  = set_stb_i && (set_addr_i == sample_link_pkg::SR_SIMTIMER);
   assign wr_periodic = set_stb_i && (set_addr_i == sample_link_pkg::SR_SIMTIMER + 8'd1);

   ////////////////////////////////////////
   // One-shot
   // Loaded with N, counts to zero; the last nonzero cycle is cycle N
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         onetime_cnt <= '0;
      end else if (wr_onetime) begin
         onetime_cnt <= set_data_i;                 // Zero cancels
      end else if (onetime_cnt != '0) begin
         onetime_cnt <= onetime_cnt - 1'b1;
      end
   end

   assign onetime_int_o = (onetime_cnt == 32'd1);

   ////////////////////////////////////////
   // Periodic
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         period     <= '0;
         period_cnt <= '0;
      end else if (wr_periodic) begin
         period     <= set_data_i;
         period_cnt <= set_data_i;
      end else if (period_cnt != '0) begin
         // Reload on the pulse cycle, next pulse P cycles on
         if (period_cnt == 32'd1) begin
            period_cnt <= period;
         end else begin
            period_cnt <= period_cnt - 1'b1;
         end
      end
   end

   // Count is only nonzero while a period is set
   assign periodic_int_o = (period_cnt == 32'd1);

endmodule

//--- rtl/sample_fifo.sv
// Sample FIFO: 32-bit samples in, 16-bit words out,
// high half of each sample leaves first

`timescale 1ns/10ps

module sample_fifo (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  sample_link_pkg::sample_t    sample_i,
   input  logic                        sample_stb_i,
   input  logic                        run_tx_i,
   input  logic                        pop_i,
   output sample_link_pkg::ser_word_t  word_o,
   output logic                        word_rdy_o
);

   sample_link_pkg::ser_word_t mem [2**sample_link_pkg::FIFO_AW];

   logic [sample_link_pkg::FIFO_AW-1:0] wr_ptr;
   logic [sample_link_pkg::FIFO_AW-1:0] wr_ptr_lo;     // Slot of the low half
   logic [sample_link_pkg::FIFO_AW-1:0] rd_ptr;
   logic [sample_link_pkg::FIFO_AW:0]   fill;          // Words held, 0 to 16

   logic has_room;
   logic accept;
   logic pop_ok;

   ////////////////////////////////////////
   // Accept and pop qualification
   // Room for a pair unless fill is 15 or 16
   assign has_room = ~fill[sample_link_pkg::FIFO_AW] &&
                     (fill[sample_link_pkg::FIFO_AW-1:0] != {sample_link_pkg::FIFO_AW{1'b1}});

   // Receive samples only while tx is idle, else dropped silently
   assign accept = sample_stb_i && ~run_tx_i && has_room;

   assign pop_ok    = pop_i && word_rdy_o;
   assign wr_ptr_lo = wr_ptr + 1'b1;

   ////////////////////////////////////////
   // Storage
   always_ff @(posedge dsp_clk) begin
      if (accept) begin
         mem[wr_ptr]    <= sample_i[31:16];
         mem[wr_ptr_lo] <= sample_i[15:0];
      end
   end

   ////////////////////////////////////////
   // Pointers and occupancy
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (accept) begin
            wr_ptr <= wr_ptr + 2'd2;
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({accept, pop_ok})
            2'b10:   fill <= fill + 2'd2;
            2'b01:   fill <= fill - 1'b1;
            2'b11:   fill <= fill + 1'b1;   // Two in, one out
            default: fill <= fill;
         endcase
      end
   end

   // Head word straight from memory, valid the cycle after a write
   assign word_o     = mem[rd_ptr];
   assign word_rdy_o = (fill != '0);

endmodule

//--- rtl/serdes_framer.sv
// Serdes transmit framer: off, sync and run states,
// drains the sample FIFO and fills gaps with K28.5 idles

`timescale 1ns/10ps

module serdes_framer (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  sample_link_pkg::ser_ctrl_t  ser_ctrl_i,
   input  sample_link_pkg::ser_word_t  word_i,
   input  logic                        word_rdy_i,
   output logic                        pop_o,
   output sample_link_pkg::ser_word_t  ser_t_o,
   output logic                        ser_tklsb_o,
   output logic                        ser_tkmsb_o,
   output logic                        link_up_o
);

   sample_link_pkg::framer_state_t state;

   logic [$clog2(sample_link_pkg::SYNC_LEN)-1:0] sync_cnt;

   logic link_en;
   logic sync_done;

   assign link_en   = ser_ctrl_i[3];          // Enable is the top bit
   assign sync_done = (sync_cnt == $bits(sync_cnt)'(sample_link_pkg::SYNC_LEN - 1));

   // No pop on the cycle enable drops, the FIFO keeps its words
   assign pop_o = (state == sample_link_pkg::FR_RUN) && link_en && word_rdy_i;

   ////////////////////////////////////////
   // State machine
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state    <= sample_link_pkg::FR_OFF;
         sync_cnt <= '0;
      end else begin
         case (state)
            sample_link_pkg::FR_OFF: begin
               sync_cnt <= '0;
               if (link_en) begin
                  state <= sample_link_pkg::FR_SYNC;
               end
            end
            sample_link_pkg::FR_SYNC: begin
               sync_cnt <= sync_cnt + 1'b1;        // One idle word per cycle
               if (!link_en) begin
                  state <= sample_link_pkg::FR_OFF;
               end else if (sync_done) begin
                  state <= sample_link_pkg::FR_RUN;
               end
            end
            sample_link_pkg::FR_RUN: begin
               if (!link_en) begin
                  state <= sample_link_pkg::FR_OFF;
               end
            end
            default: begin
               state <= sample_link_pkg::FR_OFF;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Output word register
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ser_t_o     <= '0;
         ser_tklsb_o <= 1'b0;
      end else if (pop_o) begin
         ser_t_o     <= word_i;                    // Data word
         ser_tklsb_o <= 1'b0;
      end else if (link_en && (state != sample_link_pkg::FR_OFF)) begin
         ser_t_o     <= sample_link_pkg::IDLE_WORD; // Sync or gap filler
         ser_tklsb_o <= 1'b1;
      end else begin
         ser_t_o     <= '0;
         ser_tklsb_o <= 1'b0;
      end
   end

   // High byte never carries a K character
   assign ser_tkmsb_o = 1'b0;

   assign link_up_o = (state == sample_link_pkg::FR_RUN);

endmodule

//--- rtl/sample_link_core.sv
// Top level of the sample link: settings registers, timers,
// sample FIFO and serdes framer

`timescale 1ns/10ps

module sample_link_core (
   input  logic                        dsp_clk,
   input  logic                        por_rst,

   // Settings bus
   input  logic                        set_stb_i,
   input  sample_link_pkg::set_addr_t  set_addr_i,
   input  sample_link_pkg::set_data_t  set_data_i,

   // Receive samples
   input  sample_link_pkg::sample_t    sample_i,
   input  logic                        sample_stb_i,
   input  logic                        run_tx_i,

   // Serdes transmit
   output sample_link_pkg::ser_word_t  ser_t_o,
   output logic                        ser_tklsb_o,
   output logic                        ser_tkmsb_o,
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,

   // Misc
   output sample_link_pkg::led_t       leds_o,
   output logic                        onetime_int_o,
   output logic                        periodic_int_o
);

   sample_link_pkg::ser_ctrl_t ser_ctrl;
   sample_link_pkg::ser_word_t fifo_word;
   logic                       fifo_rdy;
   logic                       fifo_pop;
   logic                       link_up;

   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_ctrl;

   ////////////////////////////////////////
   // Control registers and LEDs
   setting_regs setting_regs_inst (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .run_tx_i   (run_tx_i),
      .link_up_i  (link_up),
      .ser_ctrl_o (ser_ctrl),
      .leds_o     (leds_o)
   );

   event_timer event_timer_inst (
      .dsp_clk        (dsp_clk),
      .por_rst        (por_rst),
      .set_stb_i      (set_stb_i),
      .set_addr_i     (set_addr_i),
      .set_data_i     (set_data_i),
      .onetime_int_o  (onetime_int_o),
      .periodic_int_o (periodic_int_o)
   );

   ////////////////////////////////////////
   // Sample path
   sample_fifo sample_fifo_inst (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .sample_i     (sample_i),
      .sample_stb_i (sample_stb_i),
      .run_tx_i     (run_tx_i),
      .pop_i        (fifo_pop),
      .word_o       (fifo_word),
      .word_rdy_o   (fifo_rdy)
   );

   serdes_framer serdes_framer_inst (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .ser_ctrl_i  (ser_ctrl),
      .word_i      (fifo_word),
      .word_rdy_i  (fifo_rdy),
      .pop_o       (fifo_pop),
      .ser_t_o     (ser_t_o),
      .ser_tklsb_o (ser_tklsb_o),
      .ser_tkmsb_o (ser_tkmsb_o),
      .link_up_o   (link_up)
   );

endmodule

//--- tests/tb_sample_link.sv
// Testbench for the sample link core with a reference model
// Random settings writes, sample traffic through FIFO and framer, timer pulses

`timescale 1ns/10ps

module tb_sample_link;

   logic                        dsp_clk;
   logic                        por_rst;
   logic                        set_stb_i;
   sample_link_pkg::set_addr_t  set_addr_i;
   sample_link_pkg::set_data_t  set_data_i;
   sample_link_pkg::sample_t    sample_i;
   logic                        sample_stb_i;
   logic                        run_tx_i;
   sample_link_pkg::ser_word_t  ser_t_o;
   logic                        ser_tklsb_o;
   logic                        ser_tkmsb_o;
   logic                        ser_enable_o;
   logic                        ser_prbsen_o;
   logic                        ser_loopen_o;
   logic                        ser_rx_en_o;
   sample_link_pkg::led_t       leds_o;
   logic                        onetime_int_o;
   logic                        periodic_int_o;

   integer seed;
   integer rnd;
   int     mismatches;
   int     other_errs;
   int     low_cnt;
   int     n_cyc;
   int     k;
   int     guard;

   // Model state
   sample_link_pkg::ser_ctrl_t  exp_ctrl;
   sample_link_pkg::led_t       exp_led_sw;
   sample_link_pkg::led_t       exp_led_src;
   sample_link_pkg::ser_word_t  exp_q[$];         // Words not yet seen on ser_t_o
   logic                        mon_en;
   logic                        seen_data;
   int                          idle_cnt;

   sample_link_core sample_link_core_inst (
      .dsp_clk        (dsp_clk),
      .por_rst        (por_rst),
      .set_stb_i      (set_stb_i),
      .set_addr_i     (set_addr_i),
      .set_data_i     (set_data_i),
      .sample_i       (sample_i),
      .sample_stb_i   (sample_stb_i),
      .run_tx_i       (run_tx_i),
      .ser_t_o        (ser_t_o),
      .ser_tklsb_o    (ser_tklsb_o),
      .ser_tkmsb_o    (ser_tkmsb_o),
      .ser_enable_o   (ser_enable_o),
      .ser_prbsen_o   (ser_prbsen_o),
      .ser_loopen_o   (ser_loopen_o),
      .ser_rx_en_o    (ser_rx_en_o),
      .leds_o         (leds_o),
      .onetime_int_o  (onetime_int_o),
      .periodic_int_o (periodic_int_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #20 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Helpers
   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         mismatches++;
         $display("mismatch at time %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
      end
   endtask

   // Expected LEDs from the model registers and the hardware status bits
   function automatic sample_link_pkg::led_t mixed_leds(input logic link_up);
      sample_link_pkg::led_t hw;
      sample_link_pkg::led_t mix;
      hw    = '0;
      hw[4] = run_tx_i;
      hw[3] = ~run_tx_i;
      hw[1] = link_up;
      for (int b = 0; b < 8; b++) begin
         mix[b] = exp_led_src[b] ? hw[b] : exp_led_sw[b];   // Mask bit set picks hardware
      end
      return mix;
   endfunction

   task automatic check_ser_word();
      sample_link_pkg::ser_word_t exp_w;
      check_val("ser_tkmsb_o", 32'd0, 32'(ser_tkmsb_o));
      if (ser_tklsb_o) begin
         check_val("ser_t_o", 32'(sample_link_pkg::IDLE_WORD), 32'(ser_t_o));
         if (!seen_data) idle_cnt++;
      end else if (exp_q.size() == 0) begin
         other_errs++;
         $display("Data word %h at time %0t with no sample left to send", ser_t_o, $time);
      end else begin
         exp_w = exp_q.pop_front();
         check_val("ser_t_o", 32'(exp_w), 32'(ser_t_o));
         if (!seen_data && idle_cnt < sample_link_pkg::SYNC_LEN) begin
            other_errs++;
            $display("Only %0d idle words before the first data word", idle_cnt);
         end
         seen_data = 1'b1;
      end
   endtask

   // Checks land 2 ns after the edge and the caller drives next
   task automatic step();
      @(posedge dsp_clk);
      #2;
      if (mon_en) check_ser_word();
   endtask

   task automatic write_setting(input sample_link_pkg::set_addr_t addr,
                                input sample_link_pkg::set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      if (addr == sample_link_pkg::SR_SERDES) exp_ctrl = data[3:0];
      else if (addr == sample_link_pkg::SR_LED_SW) exp_led_sw = data[7:0];
      else if (addr == sample_link_pkg::SR_LED_SRC) exp_led_src = data[7:0];
   endtask

   // Accept needs tx idle and room for both halves
   task automatic drive_sample(input logic tx);
      rnd          = $random(seed);
      sample_i     = rnd;
      sample_stb_i = 1'b1;
      run_tx_i     = tx;
      if (!tx && (2**sample_link_pkg::FIFO_AW - exp_q.size() >= 2)) begin
         exp_q.push_back(sample_i[31:16]);
         exp_q.push_back(sample_i[15:0]);
      end
   endtask

   task automatic wait_drain(input int limit);
      int g;
      g = 0;
      while (exp_q.size() != 0 && g < limit) begin
         step();
         g++;
      end
      if (exp_q.size() != 0) begin
         other_errs++;
         $display("Timeout with %0d words still expected from the link", exp_q.size());
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   initial begin
      seed = 21;
      mismatches = 0;
      other_errs = 0;
      mon_en = 1'b0;
      seen_data = 1'b0;
      idle_cnt = 0;
      por_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      sample_i = '0;
      sample_stb_i = 1'b0;
      run_tx_i = 1'b0;
      exp_ctrl = '0;
      exp_led_sw = '0;
      exp_led_src = sample_link_pkg::LED_SRC_RESET;
      repeat (3) @(posedge dsp_clk);
      #2;
      por_rst = 1'b0;

      check_val("leds_o", 32'(mixed_leds(1'b0)), 32'(leds_o));
      check_val("serdes pins", 32'd0,
                32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}));
      check_val("ser_t_o", 32'd0, 32'(ser_t_o));
      check_val("K flags", 32'd0, 32'({ser_tklsb_o, ser_tkmsb_o}));
      check_val("interrupts", 32'd0, 32'({onetime_int_o, periodic_int_o}));

      // Register writes with the enable bit kept low
      for (k = 0; k <= 40; k++) begin
         step();
         check_val("leds_o", 32'(mixed_leds(1'b0)), 32'(leds_o));
         check_val("serdes pins", 32'(exp_ctrl),
                   32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}));
         set_stb_i = 1'b0;
         rnd = $random(seed);
         run_tx_i = (k < 40) ? rnd[0] : 1'b0;
         if (k < 40 && rnd[1]) begin
            case (rnd[3:2])
               2'd0:    write_setting(sample_link_pkg::SR_SERDES, {$random(seed)} & 32'h7);
               2'd1:    write_setting(sample_link_pkg::SR_LED_SW, $random(seed));
               default: write_setting(sample_link_pkg::SR_LED_SRC, $random(seed));
            endcase
         end
      end

      // Fill the FIFO with the link off
      low_cnt = 0;
      for (guard = 0; guard < 100 && low_cnt < 20; guard++) begin
         step();
         check_val("ser_t_o", 32'd0, 32'(ser_t_o));
         rnd = $random(seed);
         drive_sample(rnd[1:0] == 2'b00);
         if (!run_tx_i) low_cnt++;
      end
      step();
      sample_stb_i = 1'b0;
      run_tx_i = 1'b0;

      // Enable, sync, then drain the backlog
      step();
      write_setting(sample_link_pkg::SR_SERDES, 32'h8 | ({$random(seed)} & 32'h7));
      step();
      set_stb_i = 1'b0;
      check_val("ser_enable_o", 32'd1, 32'(ser_enable_o));
      guard = 0;
      while (!ser_tklsb_o && guard < 20) begin
         step();
         guard++;
      end
      if (!ser_tklsb_o) begin
         other_errs++;
         $display("Timeout waiting for the first idle word after enable");
      end else begin
         mon_en = 1'b1;
         idle_cnt = 1;
      end
      wait_drain(200);

      // All LEDs on hardware sources while the link is up
      step();
      write_setting(sample_link_pkg::SR_LED_SRC, 32'h0000_00ff);
      step();
      set_stb_i = 1'b0;
      check_val("leds_o", 32'(mixed_leds(1'b1)), 32'(leds_o));

      // Live traffic with gaps of two or more cycles
      for (k = 0; k < 30; k++) begin
         step();
         rnd = $random(seed);
         drive_sample(rnd[2:0] == 3'b000);
         step();
         sample_stb_i = 1'b0;
         run_tx_i = 1'b0;
         rnd = $random(seed);
         n_cyc = rnd & 3;
         repeat (n_cyc) step();
      end
      wait_drain(50);

      ////////////////////////////////////////
      // Timers
      n_cyc = 2 + ({$random(seed)} % 39);
      step();
      write_setting(sample_link_pkg::SR_SIMTIMER, n_cyc);
      for (k = 1; k <= n_cyc + 8; k++) begin
         step();
         set_stb_i = 1'b0;
         check_val("onetime_int_o", 32'(k == n_cyc), 32'(onetime_int_o));
      end

      n_cyc = 2 + ({$random(seed)} % 14);
      step();
      write_setting(sample_link_pkg::SR_SIMTIMER + 8'd1, n_cyc);
      for (k = 1; k <= 4 * n_cyc + 1; k++) begin
         step();
         set_stb_i = 1'b0;
         check_val("periodic_int_o", 32'(k % n_cyc == 0), 32'(periodic_int_o));
         if (k == 4 * n_cyc + 1) write_setting(sample_link_pkg::SR_SIMTIMER + 8'd1, 32'd0);
      end
      for (k = 0; k < 3 * n_cyc; k++) begin
         step();
         set_stb_i = 1'b0;
         check_val("periodic_int_o", 32'd0, 32'(periodic_int_o));
      end

      $display("Closing: %0d mismatches, %0d other errors", mismatches, other_errs);
      if (mismatches + other_errs == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- filelist.f
rtl/sample_link_pkg.sv
rtl/setting_regs.sv
rtl/event_timer.sv
rtl/sample_fifo.sv
rtl/serdes_framer.sv
rtl/sample_link_core.sv
tests/tb_sample_link.sv

//--- run_sim.sh
#!/bin/sh
# Build the sample link testbench with Verilator, run it, scan the log

verilator --binary --timing --top-module tb_sample_link -f filelist.f \
   -Mdir obj_dir -o tb_sample_link > build.log 2>&1 \
   && ./obj_dir/tb_sample_link > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat sim.log

grep -q "Finished with errors" sim.log \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation PASSED"; exit 0; }
